// ==== src/rv_pkg.sv ====
package rv_pkg;

    // Data path and memory sizes
    localparam int xlen        = 64;
    localparam int imem_words  = 256;
    localparam int imem_aw     = $clog2(imem_words);
    localparam int dram_words  = 256;
    localparam int dram_aw     = $clog2(dram_words);
    localparam int bus_aw      = 32;

    // Address map
    localparam logic [bus_aw-1:0] ram_base = 32'h0000_1000;
    localparam logic [bus_aw-1:0] ram_top  = ram_base + bus_aw'(8 * dram_words);
    localparam logic [bus_aw-1:0] con_base = 32'h8000_0000;
    localparam logic [bus_aw-1:0] key_base = 32'h8000_0010;

    // PC wraps back to zero at the end of instruction memory
    localparam logic [31:0] pc_limit = 32'(imem_words * 4);

    // Console flow control
    localparam int con_credits = 4;
    localparam int cred_w      = $clog2(con_credits + 1);

    // Major opcodes and function fields
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_opimm = 7'b0010011;
    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [2:0] f3_add    = 3'b000;
    localparam logic [2:0] f3_dword  = 3'b011;
    localparam logic [6:0] f7_add    = 7'b0000000;
    localparam logic [6:0] f7_sub    = 7'b0100000;

    typedef enum logic [2:0] {
        op_nop, op_lui, op_addi, op_add, op_sub, op_ld, op_sd
    } op_e;

    typedef struct packed {
        op_e             op;
        logic [4:0]      rd;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        logic            valid;
    } dec_t;

    typedef struct packed {
        logic [bus_aw-1:0] addr;
        logic [xlen-1:0]   wdata;
        logic              we;
        logic              re;
    } bus_req_t;

    typedef struct packed {
        op_e             op;
        logic [4:0]      rd;
        logic [xlen-1:0] alu;
        logic            valid;
    } exe_t;

endpackage

// ==== src/instr_mem.sv ====
module instr_mem (
    input  logic                       CLOCK_50,
    input  logic                       imem_we,
    input  logic [rv_pkg::imem_aw-1:0] imem_addr,
    input  logic [31:0]                imem_data,
    input  logic [rv_pkg::imem_aw-1:0] fetch_addr,
    output logic [31:0]                instr
);
    import rv_pkg::*;

    logic [31:0] mem [imem_words];
    logic [31:0] rd_q;

    // Words are kept exactly as the loader wrote them
    always_ff @(posedge CLOCK_50) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        rd_q <= mem[fetch_addr];
    end

    // Image is stored byte-swapped, undo it on the way out
    assign instr = {rd_q[7:0], rd_q[15:8], rd_q[23:16], rd_q[31:24]};

endmodule

// ==== src/rv_decode.sv ====
module rv_decode (
    input  logic                       CLOCK_50,
    input  logic                       reset,
    input  logic                       run,
    input  logic                       retire,
    output logic [rv_pkg::imem_aw-1:0] fetch_addr,
    input  logic [31:0]                instr,
    input  logic [31:0]                pc,
    output logic [4:0]                 rs1_addr,
    output logic [4:0]                 rs2_addr,
    input  logic [rv_pkg::xlen-1:0]    rs1_data,
    input  logic [rv_pkg::xlen-1:0]    rs2_data,
    output rv_pkg::dec_t               dec
);
    import rv_pkg::*;

    typedef enum logic [1:0] {s_idle, s_fetch, s_decode, s_wait} state_t;

    state_t          state;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    op_e             op;
    logic [xlen-1:0] imm;

    assign fetch_addr = pc[imem_aw+1:2];

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    // LUI result is sign-extended from bit 31 on RV64
    assign imm_u = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        op  = op_nop;
        imm = imm_i;
        case (opcode)
            opc_lui: begin
                op  = op_lui;
                imm = imm_u;
            end
            opc_opimm: if (funct3 == f3_add) op = op_addi;
            opc_op: begin
                if (funct3 == f3_add && funct7 == f7_add) op = op_add;
                if (funct3 == f3_add && funct7 == f7_sub) op = op_sub;
            end
            opc_load: if (funct3 == f3_dword) op = op_ld;
            opc_store: begin
                if (funct3 == f3_dword) op = op_sd;
                imm = imm_s;
            end
            default: op = op_nop;
        endcase
    end

    // Step token: fetch, then decode, then wait for retire
    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            state <= s_idle;
        end else if (!run) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:   state <= s_fetch;
                s_fetch:  state <= s_decode;
                s_decode: state <= s_wait;
                s_wait:   if (retire) state <= s_fetch;
                default:  state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            dec <= '0;
        end else if (run && state == s_decode) begin
            dec.op      <= op;
            dec.rd      <= instr[11:7];
            dec.rs1_val <= rs1_data;
            dec.rs2_val <= rs2_data;
            dec.imm     <= imm;
            dec.valid   <= 1'b1;
        end else begin
            dec.valid <= 1'b0;
        end
    end

endmodule

// ==== src/rv_execute.sv ====
module rv_execute (
    input  logic             CLOCK_50,
    input  logic             reset,
    input  rv_pkg::dec_t     dec,
    input  logic             con_ok,
    output rv_pkg::bus_req_t breq,
    output rv_pkg::exe_t     exe
);
    import rv_pkg::*;

    dec_t            hold;
    logic            holding;
    dec_t            cur;
    logic            cur_valid;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] alu;
    logic            con_store;
    logic            stall;
    logic            go;

    // A stalled instruction is replayed from the hold register
    assign cur       = holding ? hold : dec;
    assign cur_valid = holding || dec.valid;

    // Effective address and ADDI share one adder
    assign sum = cur.rs1_val + cur.imm;

    always_comb begin
        case (cur.op)
            op_lui:  alu = cur.imm;
            op_addi: alu = sum;
            op_add:  alu = cur.rs1_val + cur.rs2_val;
            op_sub:  alu = cur.rs1_val - cur.rs2_val;
            op_ld:   alu = sum;
            op_sd:   alu = sum;
            default: alu = '0;
        endcase
    end

    assign con_store = cur.op == op_sd && sum[bus_aw-1:0] == con_base;
    assign stall     = cur_valid && con_store && !con_ok;
    assign go        = cur_valid && !stall;

    // Bus request goes out in the accepting cycle only
    always_comb begin
        breq.addr  = sum[bus_aw-1:0];
        breq.wdata = cur.rs2_val;
        breq.we    = go && cur.op == op_sd;
        breq.re    = go && cur.op == op_ld;
    end

    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            holding <= 1'b0;
        end else begin
            holding <= stall;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (stall) begin
            hold <= cur;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            exe <= '0;
        end else begin
            exe.valid <= go;
            if (go) begin
                exe.op  <= cur.op;
                exe.rd  <= cur.rd;
                exe.alu <= alu;
            end
        end
    end

endmodule

// ==== src/rv_result.sv ====
module rv_result (
    input  logic                    CLOCK_50,
    input  logic                    reset,
    input  logic                    run,
    input  rv_pkg::exe_t            exe,
    input  logic [rv_pkg::xlen-1:0] rdata,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data,
    output logic [31:0]             pc,
    output logic                    retire
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            wen;
    logic [xlen-1:0] wdata;
    logic [31:0]     pc_inc;

    // x0 reads back as zero whatever gets written to it
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    assign wen   = exe.valid && exe.op != op_nop && exe.op != op_sd;
    // Load data shows up in the same cycle as the result stage
    assign wdata = (exe.op == op_ld) ? rdata : exe.alu;

    always_ff @(posedge CLOCK_50) begin
        if (wen) begin
            regs[exe.rd] <= wdata;
        end
    end

    assign pc_inc = pc + 32'd4;

    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (exe.valid) begin
            pc <= (pc_inc == pc_limit) ? '0 : pc_inc;
        end
    end

    // Hands the step token back to decode
    assign retire = exe.valid;

endmodule

// ==== src/bus_decoder.sv ====
module bus_decoder (
    input  logic                    CLOCK_50,
    input  logic                    reset,
    input  rv_pkg::bus_req_t        breq,
    output logic [rv_pkg::xlen-1:0] rdata,
    output logic                    con_ok,
    input  logic                    key_valid,
    input  logic [7:0]              key_code,
    input  logic                    con_credit,
    output logic                    con_valid,
    output logic [7:0]              con_data
);
    import rv_pkg::*;

    logic [xlen-1:0]    ram [dram_words];
    logic [bus_aw-1:0]  ram_off;
    logic [dram_aw-1:0] ram_idx;
    logic               ram_sel;
    logic               key_sel;
    logic               con_sel;
    logic               key_pend;
    logic [7:0]         key_q;
    logic [cred_w-1:0]  credits;
    logic               take;

    assign ram_sel = breq.addr >= ram_base && breq.addr < ram_top;
    assign key_sel = breq.addr == key_base;
    assign con_sel = breq.addr == con_base;

    // RAM is addressed in doublewords
    assign ram_off = breq.addr - ram_base;
    assign ram_idx = ram_off[dram_aw+2:3];

    always_ff @(posedge CLOCK_50) begin
        if (breq.we && ram_sel) begin
            ram[ram_idx] <= breq.wdata;
        end
        if (breq.re) begin
            if (ram_sel) rdata <= ram[ram_idx];
            else if (key_sel) rdata <= {{(xlen-9){1'b0}}, key_pend, key_q};
            else rdata <= '0;
        end
        con_data <= breq.wdata[7:0];
    end

    // A new key wins over a read that clears the flag
    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            key_pend <= 1'b0;
            key_q    <= '0;
        end else if (key_valid) begin
            key_pend <= 1'b1;
            key_q    <= key_code;
        end else if (breq.re && key_sel) begin
            key_pend <= 1'b0;
        end
    end

    assign take = breq.we && con_sel;

    always_ff @(posedge CLOCK_50 or negedge reset) begin
        if (!reset) begin
            con_valid <= 1'b0;
            credits   <= cred_w'(con_credits);
        end else begin
            con_valid <= take;
            case ({take, con_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign con_ok = credits != '0;

endmodule

// ==== src/cpu_board_top.sv ====
module cpu_board_top (
    input  logic                       CLOCK_50,
    input  logic                       reset,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [rv_pkg::imem_aw-1:0] imem_addr,
    input  logic [31:0]                imem_data,
    input  logic                       key_valid,
    input  logic [7:0]                 key_code,
    input  logic                       con_credit,
    output logic                       con_valid,
    output logic [7:0]                 con_data
);
    import rv_pkg::*;

    logic [imem_aw-1:0] fetch_addr;
    logic [31:0]        instr;
    logic [31:0]        pc;
    logic               retire;
    logic [4:0]         rs1_addr;
    logic [4:0]         rs2_addr;
    logic [xlen-1:0]    rs1_data;
    logic [xlen-1:0]    rs2_data;
    logic [xlen-1:0]    rdata;
    logic               con_ok;
    dec_t               dec;
    exe_t               exe;
    bus_req_t           breq;

    instr_mem u_imem (
        .CLOCK_50(CLOCK_50), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_data(imem_data), .fetch_addr(fetch_addr), .instr(instr)
    );

    rv_decode u_decode (
        .CLOCK_50(CLOCK_50), .reset(reset), .run(run), .retire(retire),
        .fetch_addr(fetch_addr), .instr(instr), .pc(pc),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .dec(dec)
    );

    rv_execute u_execute (
        .CLOCK_50(CLOCK_50), .reset(reset), .dec(dec), .con_ok(con_ok),
        .breq(breq), .exe(exe)
    );

    rv_result u_result (
        .CLOCK_50(CLOCK_50), .reset(reset), .run(run), .exe(exe), .rdata(rdata),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .retire(retire)
    );

    bus_decoder u_bus (
        .CLOCK_50(CLOCK_50), .reset(reset), .breq(breq), .rdata(rdata),
        .con_ok(con_ok), .key_valid(key_valid), .key_code(key_code),
        .con_credit(con_credit), .con_valid(con_valid), .con_data(con_data)
    );

endmodule

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] take_bits(ref logic [31:0] state, input int n);
    logic [31:0] bits;
    logic        lsb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lsb   = state[0];
        state = state >> 1;
        if (lsb) state = state ^ 32'h8020_0003;
        bits  = {bits[30:0], lsb};
    end
    return bits;
endfunction

// RV64I encoders for the six supported instructions
function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_op(input logic [6:0] f7, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_ld(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b011, rd, 7'b0000011};
endfunction

function automatic logic [31:0] enc_sd(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
endfunction

// Loader image is little-endian, so each word goes in byte-reversed
function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// Instruction-set model, collects every byte written to the console
function automatic void ref_run(input logic [31:0] prog[$], input bit kpend,
                                input logic [7:0] kcode, ref logic [7:0] out_q[$]);
    logic [63:0] x [32];
    logic [63:0] ram [256];
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] addr;
    bit          flag;
    bit          wr;
    flag = kpend;
    pc   = '0;
    foreach (x[r]) x[r] = '0;
    repeat (prog.size()) begin
        w    = (pc / 4 < prog.size()) ? prog[pc / 4] : 32'h0000_0013;
        a    = x[w[19:15]];
        b    = x[w[24:20]];
        wr   = 1'b0;
        res  = '0;
        addr = (w[6:0] == 7'h23) ? 32'(a + {{52{w[31]}}, w[31:25], w[11:7]})
                                 : 32'(a + {{52{w[31]}}, w[31:20]});
        case (w[6:0])
            7'h37: begin
                res = {{32{w[31]}}, w[31:12], 12'h000};
                wr  = 1'b1;
            end
            7'h13: begin
                res = a + {{52{w[31]}}, w[31:20]};
                wr  = w[14:12] == 3'd0;
            end
            7'h33: begin
                res = (w[31:25] == 7'h20) ? a - b : a + b;
                wr  = w[14:12] == 3'd0 && (w[31:25] == 7'h00 || w[31:25] == 7'h20);
            end
            7'h03: if (w[14:12] == 3'd3) begin
                wr = 1'b1;
                if (addr >= 32'h1000 && addr < 32'h1800) begin
                    res = ram[(addr - 32'h1000) >> 3];
                end else if (addr == 32'h8000_0010) begin
                    // Reading the key register clears its pending flag
                    res  = {55'd0, flag, kcode};
                    flag = 1'b0;
                end
            end
            7'h23: if (w[14:12] == 3'd3) begin
                if (addr >= 32'h1000 && addr < 32'h1800) ram[(addr - 32'h1000) >> 3] = b;
                else if (addr == 32'h8000_0000) out_q.push_back(b[7:0]);
            end
            default: ;
        endcase
        if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
        pc = (pc + 4 == imem_words * 4) ? 32'd0 : pc + 4;
    end
endfunction

`endif

// ==== sim/tb_cpu_board.sv ====
module tb_cpu_board;
    import rv_pkg::*;

    // Instruction total over all five programs
    localparam int instr_total = 17 + 18 + 12 + 49 + 239;
    // Four cycles per instruction, a long credit gap per withheld beat,
    // reset and load of each test, then margin
    localparam int timeout_cycles = instr_total * 4 + 24 * 90 + 5 * (imem_words + 16) + 2000;

    logic               CLOCK_50 = 1'b0;
    logic               reset;
    logic               run;
    logic               imem_we;
    logic [imem_aw-1:0] imem_addr;
    logic [31:0]        imem_data;
    logic               key_valid;
    logic [7:0]         key_code;
    logic               con_credit = 1'b0;
    logic               con_valid;
    logic [7:0]         con_data;

    logic [31:0] prog_q[$];
    logic [7:0]  exp_q[$];
    logic [31:0] gen_lfsr = 32'h2035_b81c;
    logic [31:0] sink_lfsr = 32'h2035_b81c;
    string       test_name = "startup";
    bit          loading = 1'b1;
    bit          withhold = 1'b0;
    int          sink_credits = con_credits;
    int          gap = 0;
    int          val_errs = 0;
    int          proto_errs = 0;
    int          cycle_count = 0;

`include "tb_ref_model.svh"

    cpu_board_top DUT (.*);

    initial forever #20 CLOCK_50 = ~CLOCK_50;

    always @(posedge CLOCK_50) cycle_count <= cycle_count + 1;

    task automatic tick();
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic run_program(input string name, input bit kpend, input logic [7:0] kcode);
        test_name = name;
        loading   = 1'b1;
        run       = 1'b0;
        tick();
        reset = 1'b0;
        repeat (10) tick();
        reset = 1'b1;
        // Unused words hold ADDI x0, x0, index
        for (int i = 0; i < imem_words; i++) begin
            imem_we   = 1'b1;
            imem_addr = imem_aw'(i);
            imem_data = swap_bytes(i < prog_q.size() ? prog_q[i] : enc_addi(5'd0, 5'd0, 12'(i)));
            tick();
        end
        imem_we = 1'b0;
        if (kpend) begin
            key_valid = 1'b1;
            key_code  = kcode;
            tick();
            key_valid = 1'b0;
        end
        ref_run(prog_q, kpend, kpend ? kcode : 8'h00, exp_q);
        loading = 1'b0;
        run     = 1'b1;
        wait (exp_q.size() == 0);
        repeat (2) tick();
        run = 1'b0;
        prog_q.delete();
    endtask

    task automatic test_arith();
        prog_q.push_back(enc_lui(5'd2, 20'h80000));
        prog_q.push_back(enc_addi(5'd5, 5'd0, 12'h123));
        prog_q.push_back(enc_addi(5'd6, 5'd0, 12'hfb3));
        prog_q.push_back(enc_op(7'h00, 5'd7, 5'd5, 5'd6));
        prog_q.push_back(enc_op(7'h20, 5'd8, 5'd5, 5'd6));
        prog_q.push_back(enc_lui(5'd9, 20'h12345));
        prog_q.push_back(enc_addi(5'd9, 5'd9, 12'h678));
        // Writes to x0 must vanish
        prog_q.push_back(enc_addi(5'd0, 5'd5, 12'h055));
        prog_q.push_back(enc_op(7'h00, 5'd0, 5'd5, 5'd6));
        prog_q.push_back(enc_op(7'h20, 5'd10, 5'd0, 5'd5));
        for (int r = 5; r <= 10; r++) prog_q.push_back(enc_sd(5'(r), 5'd2, 12'h000));
        prog_q.push_back(enc_sd(5'd0, 5'd2, 12'h000));
        run_program("arith", 1'b0, 8'h00);
    endtask

    task automatic test_memory();
        prog_q.push_back(enc_lui(5'd1, 20'h00001));
        prog_q.push_back(enc_lui(5'd2, 20'h80000));
        prog_q.push_back(enc_addi(5'd3, 5'd1, 12'h7ff));
        prog_q.push_back(enc_addi(5'd5, 5'd0, 12'h05a));
        prog_q.push_back(enc_addi(5'd6, 5'd0, 12'hffd));
        prog_q.push_back(enc_sd(5'd5, 5'd1, 12'h000));
        prog_q.push_back(enc_sd(5'd6, 5'd1, 12'h7f8));
        prog_q.push_back(enc_addi(5'd9, 5'd0, 12'h063));
        prog_q.push_back(enc_ld(5'd7, 5'd1, 12'h000));
        prog_q.push_back(enc_ld(5'd8, 5'd1, 12'h7f8));
        // Unmapped reads at zero, just below the RAM and just past its end
        prog_q.push_back(enc_ld(5'd9, 5'd0, 12'h000));
        prog_q.push_back(enc_ld(5'd10, 5'd1, 12'hff8));
        prog_q.push_back(enc_ld(5'd11, 5'd3, 12'h001));
        for (int r = 7; r <= 11; r++) prog_q.push_back(enc_sd(5'(r), 5'd2, 12'h000));
        run_program("memory", 1'b0, 8'h00);
    endtask

    task automatic test_key();
        logic [7:0]  code;
        logic [11:0] set_off;
        logic [11:0] clr_off;
        code    = 8'(take_bits(gen_lfsr, 8));
        set_off = 12'h000 - {4'h1, code};
        clr_off = 12'h000 - {4'h0, code};
        prog_q.push_back(enc_lui(5'd2, 20'h80000));
        prog_q.push_back(enc_addi(5'd9, 5'd0, 12'h046));
        prog_q.push_back(enc_ld(5'd5, 5'd2, 12'h010));
        prog_q.push_back(enc_ld(5'd6, 5'd2, 12'h010));
        prog_q.push_back(enc_sd(5'd5, 5'd2, 12'h000));
        prog_q.push_back(enc_sd(5'd6, 5'd2, 12'h000));
        // Marker reaches the console only when byte 1 holds the expected flag
        prog_q.push_back(enc_op(7'h00, 5'd7, 5'd2, 5'd5));
        prog_q.push_back(enc_addi(5'd7, 5'd7, set_off));
        prog_q.push_back(enc_sd(5'd9, 5'd7, 12'h000));
        prog_q.push_back(enc_op(7'h00, 5'd8, 5'd2, 5'd6));
        prog_q.push_back(enc_addi(5'd8, 5'd8, clr_off));
        prog_q.push_back(enc_sd(5'd9, 5'd8, 12'h000));
        run_program("key", 1'b1, code);
    endtask

    task automatic test_backpressure();
        withhold = 1'b1;
        prog_q.push_back(enc_lui(5'd2, 20'h80000));
        repeat (24) begin
            prog_q.push_back(enc_addi(5'd5, 5'd0, 12'(take_bits(gen_lfsr, 12))));
            prog_q.push_back(enc_sd(5'd5, 5'd2, 12'h000));
        end
        run_program("backpressure", 1'b0, 8'h00);
        withhold = 1'b0;
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  kind;
        logic [1:0]  dest;
        logic [11:0] slot;
        rd   = 5'(take_bits(gen_lfsr, 5));
        rs1  = 5'(take_bits(gen_lfsr, 5));
        rs2  = 5'(take_bits(gen_lfsr, 5));
        kind = 3'(take_bits(gen_lfsr, 3));
        dest = 2'(take_bits(gen_lfsr, 2));
        slot = 12'(take_bits(gen_lfsr, 3) << 3);
        // x1 and x2 keep the RAM and console base addresses
        if (rd == 5'd1 || rd == 5'd2) rd = rd + 5'd8;
        case (kind)
            3'd0: return enc_lui(rd, 20'(take_bits(gen_lfsr, 20)));
            3'd1: return enc_addi(rd, rs1, 12'(take_bits(gen_lfsr, 12)));
            3'd2: return enc_op(7'h00, rd, rs1, rs2);
            3'd3: return enc_op(7'h20, rd, rs1, rs2);
            3'd4: begin
                if (dest[1] == 1'b0) return enc_ld(rd, 5'd1, slot);
                if (dest == 2'd2) return enc_ld(rd, 5'd2, 12'h010);
                return enc_ld(rd, 5'd0, 12'(take_bits(gen_lfsr, 12)));
            end
            3'd5: begin
                if (dest[1] == 1'b0) return enc_sd(rs2, 5'd2, 12'h000);
                if (dest == 2'd2) return enc_sd(rs2, 5'd1, slot);
                return enc_sd(rs2, 5'd0, 12'(take_bits(gen_lfsr, 12)));
            end
            3'd6: return {25'(take_bits(gen_lfsr, 25)), 7'b0001111};
            default: return enc_sd(rs2, 5'd2, 12'h000);
        endcase
    endfunction

    task automatic test_random();
        prog_q.push_back(enc_lui(5'd1, 20'h00001));
        prog_q.push_back(enc_lui(5'd2, 20'h80000));
        for (int r = 3; r < 32; r++) begin
            prog_q.push_back(enc_addi(5'(r), 5'd0, 12'(take_bits(gen_lfsr, 12))));
        end
        for (int k = 0; k < 8; k++) prog_q.push_back(enc_sd(5'(4 + k), 5'd1, 12'(8 * k)));
        repeat (200) prog_q.push_back(random_instr());
        run_program("random", 1'b0, 8'h00);
    endtask

    // Console sink returns credits with long gaps while withholding
    always @(posedge CLOCK_50) begin
        #2;
        con_credit = 1'b0;
        if (gap > 0) begin
            gap = gap - 1;
        end else if (sink_credits < con_credits && take_bits(sink_lfsr, 1) == 32'd1) begin
            con_credit = 1'b1;
            if (withhold) gap = 16 + int'(take_bits(sink_lfsr, 6));
        end
    end

    always @(negedge CLOCK_50) begin
        logic [7:0] want;
        if (!reset) begin
            sink_credits = con_credits;
        end else begin
            if (con_valid) begin
                assert (!loading) else begin
                    proto_errs++;
                    $display("Console beat while the program was loading in %s", test_name);
                end
                assert (sink_credits > 0) else begin
                    proto_errs++;
                    $display("Console beat arrived with no credit left in %s", test_name);
                end
                if (sink_credits > 0) sink_credits--;
                assert (exp_q.size() > 0) else begin
                    proto_errs++;
                    $display("Console beat %02h came after the expected stream in %s",
                             con_data, test_name);
                end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (con_data === want) else begin
                        val_errs++;
                        $display("[FAIL] %s expected %02h actual %02h", test_name, want, con_data);
                    end
                end
            end
            if (con_credit) sink_credits++;
        end
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
        $display("Errors: %0d value mismatches, %0d protocol errors", val_errs, proto_errs);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset     = 1'b0;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        key_valid = 1'b0;
        key_code  = '0;
        test_arith();
        test_memory();
        test_key();
        test_backpressure();
        test_random();
        $display("Errors: %0d value mismatches, %0d protocol errors", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+sim
src/rv_pkg.sv
src/instr_mem.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/bus_decoder.sv
src/cpu_board_top.sv
sim/tb_cpu_board.sv
